// File: design/decoder_geometry_pkg.sv
package decoder_geometry_pkg;

    // rotated lattice, one round of detection nodes
    localparam int GRID_WIDTH_X = 4;  // rows
    localparam int GRID_WIDTH_Z = 2;  // columns
    localparam int NODES_PER_ROUND = GRID_WIDTH_X * GRID_WIDTH_Z;

    // two logical patches stacked along x, fused at the border row
    localparam int LOGICAL_QUBITS_PER_DIM = 2;
    localparam int FUSION_ROW = GRID_WIDTH_X / LOGICAL_QUBITS_PER_DIM;

    // edge counts per round
    localparam int NS_EDGE_COUNT = (GRID_WIDTH_X - 1) * GRID_WIDTH_Z;
    localparam int EW_EDGE_COUNT = (GRID_WIDTH_X - 1) * GRID_WIDTH_Z;
    localparam int UD_EDGE_COUNT = NODES_PER_ROUND;

    // correction word layout: NS, then EW, then UD
    localparam int NS_BASE = 0;
    localparam int EW_BASE = NS_BASE + NS_EDGE_COUNT;
    localparam int UD_BASE = EW_BASE + EW_EDGE_COUNT;
    localparam int EDGE_COUNT = UD_BASE + UD_EDGE_COUNT;

    // node (i,j) lives at bit i*GRID_WIDTH_Z+j
    typedef logic [NODES_PER_ROUND-1:0] node_vec_t;

    // one bit per edge, flagged when the edge carries a correction
    typedef logic [EDGE_COUNT-1:0] corr_vec_t;

    // link type codes of the decoding graph
    typedef enum logic [1:0] {
        EDGE_INTERNAL = 2'b00,  // both endpoints on the grid
        EDGE_ABSENT   = 2'b10,  // second endpoint off the grid
        EDGE_CUT      = 2'b11   // border row while patches are not fused
    } edge_kind_e;

endpackage

// File: design/host_bus_pkg.sv
package host_bus_pkg;

    // wishbone classic, host side only
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // register map
    typedef enum logic [3:0] {
        ADDR_ROUND      = 4'd0,
        ADDR_CONFIG     = 4'd1,
        ADDR_CORRECTION = 4'd2
    } reg_addr_e;

    // pipeline beats
    typedef struct packed {
        logic                            valid;
        logic                            first;   // new batch, forget history
        logic                            fusion;
        decoder_geometry_pkg::node_vec_t meas;
    } round_beat_t;

    typedef struct packed {
        logic                            valid;
        logic                            fusion;
        decoder_geometry_pkg::node_vec_t cur_defects;
        decoder_geometry_pkg::node_vec_t prev_defects;
    } defect_beat_t;

    typedef struct packed {
        logic                            valid;
        decoder_geometry_pkg::corr_vec_t corr;
    } corr_beat_t;

    localparam int CORR_FIFO_DEPTH = 4;
    localparam int CORR_PTR_W = $clog2(CORR_FIFO_DEPTH);
    localparam int CORR_CNT_W = $clog2(CORR_FIFO_DEPTH + 1);

    localparam int CORR_VALID_BIT = 31;
    localparam int ROUND_FIRST_BIT = 8;

endpackage

// File: design/wb_host_port.sv
`timescale 1ns/1ps

module wb_host_port (
    input  logic                      clk,
    input  logic                      reset,
    input  host_bus_pkg::wb_req_t     wb_req_i,
    output host_bus_pkg::wb_rsp_t     wb_rsp_o,
    input  logic                      room_i,
    output host_bus_pkg::round_beat_t round_o,
    output logic                      pop_o,
    input  host_bus_pkg::corr_beat_t  head_i
);

    logic                      ack_q;
    logic [31:0]               rsp_dat_q;
    logic                      fusion_q;
    logic                      pop_q;
    host_bus_pkg::round_beat_t round_q;

    logic        req_live;
    logic        round_wr;
    logic        cfg_wr;
    logic        corr_rd;
    logic        take;
    logic [31:0] rd_word;

    // address decode and read mux
    always_comb begin
        req_live = wb_req_i.cyc && wb_req_i.stb && !ack_q;  // never ack twice in a row
        round_wr = 1'b0;
        cfg_wr = 1'b0;
        corr_rd = 1'b0;
        rd_word = '0;
        case (host_bus_pkg::reg_addr_e'(wb_req_i.adr))
            host_bus_pkg::ADDR_ROUND: begin
                round_wr = wb_req_i.we;
            end
            host_bus_pkg::ADDR_CONFIG: begin
                cfg_wr = wb_req_i.we;
                rd_word[0] = fusion_q;
            end
            host_bus_pkg::ADDR_CORRECTION: begin
                corr_rd = !wb_req_i.we;
                if (head_i.valid) begin
                    rd_word[host_bus_pkg::CORR_VALID_BIT] = 1'b1;
                    rd_word[decoder_geometry_pkg::EDGE_COUNT-1:0] = head_i.corr;
                end
            end
            default: ;  // unmapped, ack and read zero
        endcase
        // a round write holds off until the buffer has a free slot
        take = req_live && (!round_wr || room_i);
    end

    always_ff @(posedge clk) begin
        if (take) begin
            rsp_dat_q <= rd_word;
        end
        round_q.meas <= wb_req_i.dat[decoder_geometry_pkg::NODES_PER_ROUND-1:0];
        round_q.first <= wb_req_i.dat[host_bus_pkg::ROUND_FIRST_BIT];
        round_q.fusion <= fusion_q;  // stamp with the fusion in force now
        if (reset) begin
            ack_q <= 1'b0;
            fusion_q <= 1'b0;
            pop_q <= 1'b0;
            round_q.valid <= 1'b0;
        end else begin
            ack_q <= take;
            pop_q <= take && corr_rd && head_i.valid;
            round_q.valid <= take && round_wr;
            if (take && cfg_wr) begin
                fusion_q <= wb_req_i.dat[0];
            end
        end
    end

    assign wb_rsp_o = '{ack: ack_q, dat: rsp_dat_q};
    assign round_o = round_q;  // valid in the ack cycle
    assign pop_o = pop_q;      // pop lands with the read ack

endmodule

// File: design/syndrome_diff.sv
`timescale 1ns/1ps

module syndrome_diff (
    input  logic                       clk,
    input  logic                       reset,
    input  host_bus_pkg::round_beat_t  round_i,
    output host_bus_pkg::defect_beat_t defect_o
);

    decoder_geometry_pkg::node_vec_t prev_meas_q;  // last round measured
    decoder_geometry_pkg::node_vec_t prev_def_q;   // last round's detection events
    decoder_geometry_pkg::node_vec_t base_meas;
    decoder_geometry_pkg::node_vec_t cur_def;
    decoder_geometry_pkg::node_vec_t prev_def;
    host_bus_pkg::defect_beat_t      defect_q;

    // first round of a batch sees an empty history
    always_comb begin
        base_meas = round_i.first ? '0 : prev_meas_q;
        prev_def = round_i.first ? '0 : prev_def_q;
        cur_def = round_i.meas ^ base_meas;
    end

    always_ff @(posedge clk) begin
        defect_q.fusion <= round_i.fusion;
        defect_q.cur_defects <= cur_def;
        defect_q.prev_defects <= prev_def;
        if (reset) begin
            defect_q.valid <= 1'b0;
            prev_meas_q <= '0;
            prev_def_q <= '0;
        end else begin
            defect_q.valid <= round_i.valid;
            if (round_i.valid) begin
                prev_meas_q <= round_i.meas;
                prev_def_q <= cur_def;
            end
        end
    end

    assign defect_o = defect_q;

endmodule

// File: design/pair_matcher.sv
`timescale 1ns/1ps

module pair_matcher (
    input  logic                       clk,
    input  logic                       reset,
    input  host_bus_pkg::defect_beat_t defect_i,
    output host_bus_pkg::corr_beat_t   corr_o
);

    host_bus_pkg::corr_beat_t        corr_q;
    decoder_geometry_pkg::corr_vec_t corr_next;
    decoder_geometry_pkg::edge_kind_e ns_kind;
    decoder_geometry_pkg::edge_kind_e ew_kind;
    int                              ns_col;
    int                              ew_col;

    // link type of an NS or EW edge in row `row` whose far endpoint sits in column `col`
    function automatic decoder_geometry_pkg::edge_kind_e edge_kind(
        input int   row,
        input int   col,
        input logic fusion
    );
        if (col >= decoder_geometry_pkg::GRID_WIDTH_Z) begin
            return decoder_geometry_pkg::EDGE_ABSENT;
        end
        if (row == decoder_geometry_pkg::FUSION_ROW && !fusion) begin
            return decoder_geometry_pkg::EDGE_CUT;
        end
        return decoder_geometry_pkg::EDGE_INTERNAL;
    endfunction

    // defect at node (row,col), off-grid nodes never carry one
    function automatic logic node_at(
        input decoder_geometry_pkg::node_vec_t v,
        input int                              row,
        input int                              col
    );
        if (col >= decoder_geometry_pkg::GRID_WIDTH_Z) begin
            return 1'b0;
        end
        return v[row * decoder_geometry_pkg::GRID_WIDTH_Z + col];
    endfunction

    always_comb begin
        corr_next = '0;
        ns_col = 0;
        ew_col = 0;
        ns_kind = decoder_geometry_pkg::EDGE_ABSENT;
        ew_kind = decoder_geometry_pkg::EDGE_ABSENT;
        for (int i = 1; i < decoder_geometry_pkg::GRID_WIDTH_X; i++) begin
            for (int c = 0; c < decoder_geometry_pkg::GRID_WIDTH_Z; c++) begin
                ns_col = (i % 2 == 1) ? c : c + 1;  // even rows lean east going south
                ew_col = (i % 2 == 1) ? c + 1 : c;  // odd rows lean east going north
                ns_kind = edge_kind(i, ns_col, defect_i.fusion);
                ew_kind = edge_kind(i, ew_col, defect_i.fusion);
                corr_next[decoder_geometry_pkg::NS_BASE + (i - 1) *
                          decoder_geometry_pkg::GRID_WIDTH_Z + c] =
                    (ns_kind == decoder_geometry_pkg::EDGE_INTERNAL) &&
                    node_at(defect_i.cur_defects, i - 1, c) &&
                    node_at(defect_i.cur_defects, i, ns_col);
                corr_next[decoder_geometry_pkg::EW_BASE + (i - 1) *
                          decoder_geometry_pkg::GRID_WIDTH_Z + c] =
                    (ew_kind == decoder_geometry_pkg::EDGE_INTERNAL) &&
                    node_at(defect_i.cur_defects, i, c) &&
                    node_at(defect_i.cur_defects, i - 1, ew_col);
            end
        end
        // time-like edges join a node to itself one round earlier
        for (int n = 0; n < decoder_geometry_pkg::NODES_PER_ROUND; n++) begin
            corr_next[decoder_geometry_pkg::UD_BASE + n] =
                defect_i.prev_defects[n] && defect_i.cur_defects[n];
        end
    end

    always_ff @(posedge clk) begin
        corr_q.corr <= corr_next;
        if (reset) begin
            corr_q.valid <= 1'b0;
        end else begin
            corr_q.valid <= defect_i.valid;
        end
    end

    assign corr_o = corr_q;

endmodule

// File: design/correction_buffer.sv
`timescale 1ns/1ps

module correction_buffer (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     reserve_i,
    input  host_bus_pkg::corr_beat_t corr_i,
    input  logic                     pop_i,
    output host_bus_pkg::corr_beat_t head_o,
    output logic                     room_o
);

    decoder_geometry_pkg::corr_vec_t mem [host_bus_pkg::CORR_FIFO_DEPTH];

    logic [host_bus_pkg::CORR_PTR_W-1:0] wr_ptr_q;
    logic [host_bus_pkg::CORR_PTR_W-1:0] rd_ptr_q;
    logic [host_bus_pkg::CORR_CNT_W-1:0] count_q;     // entries stored
    logic [host_bus_pkg::CORR_CNT_W-1:0] reserved_q;  // rounds accepted but not yet popped
    logic                                do_pop;

    assign do_pop = pop_i && (count_q != '0);

    // storage, no reset needed
    always_ff @(posedge clk) begin
        if (corr_i.valid) begin
            mem[wr_ptr_q] <= corr_i.corr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q <= '0;
            reserved_q <= '0;
        end else begin
            if (corr_i.valid) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;  // depth is a power of two, wraps
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_q + corr_i.valid - do_pop;
            reserved_q <= reserved_q + reserve_i - do_pop;
        end
    end

    assign head_o = '{valid: count_q != '0, corr: mem[rd_ptr_q]};
    assign room_o = reserved_q < host_bus_pkg::CORR_CNT_W'(host_bus_pkg::CORR_FIFO_DEPTH);

endmodule

// File: design/surface_decoder_top.sv
`timescale 1ns/1ps

module surface_decoder_top (
    input  logic                  clk,
    input  logic                  reset,
    input  host_bus_pkg::wb_req_t wb_req_i,
    output host_bus_pkg::wb_rsp_t wb_rsp_o
);

    host_bus_pkg::round_beat_t  round_beat;
    host_bus_pkg::defect_beat_t defect_beat;
    host_bus_pkg::corr_beat_t   corr_beat;
    host_bus_pkg::corr_beat_t   head_beat;
    logic                       room;
    logic                       pop;

    wb_host_port wb_host_port_inst (
        .clk      (clk),
        .reset    (reset),
        .wb_req_i (wb_req_i),
        .wb_rsp_o (wb_rsp_o),
        .room_i   (room),
        .round_o  (round_beat),
        .pop_o    (pop),
        .head_i   (head_beat)
    );

    syndrome_diff syndrome_diff_inst (
        .clk      (clk),
        .reset    (reset),
        .round_i  (round_beat),
        .defect_o (defect_beat)
    );

    pair_matcher pair_matcher_inst (
        .clk      (clk),
        .reset    (reset),
        .defect_i (defect_beat),
        .corr_o   (corr_beat)
    );

    // accepted round claims its slot right away
    correction_buffer correction_buffer_inst (
        .clk       (clk),
        .reset     (reset),
        .reserve_i (round_beat.valid),
        .corr_i    (corr_beat),
        .pop_i     (pop),
        .head_o    (head_beat),
        .room_o    (room)
    );

endmodule

// File: test/surface_decoder_assert.sv
`timescale 1ns/1ps

module surface_decoder_assert (
    input logic                  clk,
    input logic                  reset,
    input host_bus_pkg::wb_req_t wb_req_i,
    input host_bus_pkg::wb_rsp_t wb_rsp_o
);

    // ack answers a live request only
    ack_needs_request: assert property (@(posedge clk) disable iff (reset)
        wb_rsp_o.ack |-> (wb_req_i.cyc && wb_req_i.stb))
        else $error("ack without an active request");

    ack_single_cycle: assert property (@(posedge clk) disable iff (reset)
        wb_rsp_o.ack |=> !wb_rsp_o.ack)
        else $error("ack high for two cycles in a row");

    // only the valid flag and the edge bits may be set
    corr_read_clean: assert property (@(posedge clk) disable iff (reset)
        (wb_rsp_o.ack && !wb_req_i.we && wb_req_i.adr == host_bus_pkg::ADDR_CORRECTION)
        |-> (wb_rsp_o.dat[30:20] == '0))
        else $error("correction read with bits 30..20 set");

endmodule

bind surface_decoder_top surface_decoder_assert surface_decoder_assert_inst (.*);

// File: test/surface_decoder_tb.sv
`timescale 1ns/1ps

module surface_decoder_tb;

    localparam time CLK_PERIOD = 40ns;
    localparam time DRIVE_DELAY = 2ns;
    localparam int ACK_TIMEOUT = 50;   // cycles per bus access
    localparam int POLL_LIMIT = 20;    // correction reads before giving up
    localparam int STALL_CYCLES = 20;
    localparam int RANDOM_ROUNDS = 40;
    localparam int SEED = 6;

    logic                  clk;
    logic                  reset;
    host_bus_pkg::wb_req_t wb_req;
    host_bus_pkg::wb_rsp_t wb_rsp;

    decoder_geometry_pkg::corr_vec_t expected_q[$];
    decoder_geometry_pkg::node_vec_t model_meas;  // model history
    decoder_geometry_pkg::node_vec_t model_def;
    logic                            fusion;      // last value written to CONFIG
    int                              outstanding; // rounds accepted, not yet read

    surface_decoder_top surface_decoder_top_inst (
        .clk      (clk),
        .reset    (reset),
        .wb_req_i (wb_req),
        .wb_rsp_o (wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_corr(input string name, input decoder_geometry_pkg::corr_vec_t got,
                              input decoder_geometry_pkg::corr_vec_t exp);
        if (got !== exp) begin
            report_failure($sformatf("FAILED at %0t: %s is %h, expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("FAILED at %0t: %s is %h, expected %h",
                                     $time, name, got, exp));
        end
    endtask

    // link type of an NS or EW edge whose far endpoint lies in column far_col
    function automatic decoder_geometry_pkg::edge_kind_e classify(input int row,
                                                                 input int far_col,
                                                                 input logic fus);
        if (far_col > decoder_geometry_pkg::GRID_WIDTH_Z - 1) begin
            return decoder_geometry_pkg::EDGE_ABSENT;
        end else if (row == decoder_geometry_pkg::FUSION_ROW && !fus) begin
            return decoder_geometry_pkg::EDGE_CUT;
        end
        return decoder_geometry_pkg::EDGE_INTERNAL;
    endfunction

    // applies the syndrome and pairing rules and advances the model history
    function automatic decoder_geometry_pkg::corr_vec_t expected_corr(
        input decoder_geometry_pkg::node_vec_t meas, input logic first, input logic fus);
        decoder_geometry_pkg::node_vec_t cur;
        decoder_geometry_pkg::node_vec_t prev;
        decoder_geometry_pkg::corr_vec_t corr;
        int                              far_c;
        int                              idx;
        cur = first ? meas : meas ^ model_meas;
        prev = first ? '0 : model_def;
        corr = '0;
        for (int i = 1; i < decoder_geometry_pkg::GRID_WIDTH_X; i++) begin
            for (int c = 0; c < decoder_geometry_pkg::GRID_WIDTH_Z; c++) begin
                idx = (i - 1) * decoder_geometry_pkg::GRID_WIDTH_Z + c;
                far_c = (i % 2 == 1) ? c : c + 1;  // north-south edge from (i-1,c) to (i,far_c)
                if (classify(i, far_c, fus) == decoder_geometry_pkg::EDGE_INTERNAL) begin
                    corr[decoder_geometry_pkg::NS_BASE + idx] =
                        cur[(i - 1) * decoder_geometry_pkg::GRID_WIDTH_Z + c] &&
                        cur[i * decoder_geometry_pkg::GRID_WIDTH_Z + far_c];
                end
                far_c = (i % 2 == 0) ? c : c + 1;  // east-west edge from (i,c) to (i-1,far_c)
                if (classify(i, far_c, fus) == decoder_geometry_pkg::EDGE_INTERNAL) begin
                    corr[decoder_geometry_pkg::EW_BASE + idx] =
                        cur[i * decoder_geometry_pkg::GRID_WIDTH_Z + c] &&
                        cur[(i - 1) * decoder_geometry_pkg::GRID_WIDTH_Z + far_c];
                end
            end
        end
        for (int n = 0; n < decoder_geometry_pkg::NODES_PER_ROUND; n++) begin
            corr[decoder_geometry_pkg::UD_BASE + n] = prev[n] && cur[n];
        end
        model_meas = meas;
        model_def = cur;
        return corr;
    endfunction

    function automatic logic [31:0] round_word(input decoder_geometry_pkg::node_vec_t meas,
                                               input logic first);
        logic [31:0] w;
        w = '0;
        w[decoder_geometry_pkg::NODES_PER_ROUND-1:0] = meas;
        w[host_bus_pkg::ROUND_FIRST_BIT] = first;
        return w;
    endfunction

    // one Wishbone classic access that gives up after limit cycles without ack
    task automatic bus_cycle(input logic we, input logic [3:0] adr, input logic [31:0] dat,
                             input int limit, output logic got_ack, output logic [31:0] rdata);
        int waited;
        waited = 0;
        got_ack = 1'b0;
        rdata = '0;
        @(posedge clk);
        #DRIVE_DELAY;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        while (!got_ack && waited < limit) begin
            @(negedge clk);  // ack is stable mid-cycle
            if (wb_rsp.ack) begin
                got_ack = 1'b1;
                rdata = wb_rsp.dat;
            end
            waited++;
        end
        @(posedge clk);
        #DRIVE_DELAY;
        wb_req = '0;
    endtask

    task automatic wb_write(input host_bus_pkg::reg_addr_e adr, input logic [31:0] dat);
        logic        ok;
        logic [31:0] unused;
        bus_cycle(1'b1, adr, dat, ACK_TIMEOUT, ok, unused);
        if (!ok) begin
            report_failure($sformatf("write to address %s never got an ack", adr.name()));
        end
    endtask

    task automatic wb_read(input host_bus_pkg::reg_addr_e adr, output logic [31:0] dat);
        logic ok;
        bus_cycle(1'b0, adr, '0, ACK_TIMEOUT, ok, dat);
        if (!ok) begin
            report_failure($sformatf("read of address %s never got an ack", adr.name()));
        end
    endtask

    task automatic set_fusion(input logic value);
        wb_write(host_bus_pkg::ADDR_CONFIG, {31'b0, value});
        fusion = value;
    endtask

    task automatic push_round(input decoder_geometry_pkg::node_vec_t meas, input logic first);
        wb_write(host_bus_pkg::ADDR_ROUND, round_word(meas, first));
        expected_q.push_back(expected_corr(meas, first, fusion));
        outstanding++;
    endtask

    // polls until the buffer hands out a valid word
    task automatic read_correction(output decoder_geometry_pkg::corr_vec_t corr);
        int          polls;
        logic [31:0] rd;
        polls = 0;
        rd = '0;
        while (!rd[host_bus_pkg::CORR_VALID_BIT] && polls < POLL_LIMIT) begin
            wb_read(host_bus_pkg::ADDR_CORRECTION, rd);
            polls++;
        end
        if (!rd[host_bus_pkg::CORR_VALID_BIT]) begin
            report_failure($sformatf("no valid correction after %0d reads", POLL_LIMIT));
        end
        corr = rd[decoder_geometry_pkg::EDGE_COUNT-1:0];
        outstanding--;
    endtask

    // every valid correction read is compared against the model in order
    always @(negedge clk) begin
        if (!reset && wb_rsp.ack && !wb_req.we && wb_rsp.dat[host_bus_pkg::CORR_VALID_BIT] &&
            wb_req.adr == host_bus_pkg::ADDR_CORRECTION) begin
            if (expected_q.size() == 0) begin
                report_failure("a correction was read back with no round outstanding");
            end else begin
                check_corr("wb_rsp_o.dat[19:0]",
                           wb_rsp.dat[decoder_geometry_pkg::EDGE_COUNT-1:0],
                           expected_q.pop_front());
            end
        end
    end

    initial begin
        decoder_geometry_pkg::corr_vec_t corr;
        decoder_geometry_pkg::node_vec_t meas;
        logic [31:0]                     rd;
        logic                            acked;
        void'($urandom(SEED));
        wb_req = '0;
        reset = 1'b1;
        fusion = 1'b0;
        model_meas = '0;
        model_def = '0;
        outstanding = 0;
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        wb_read(host_bus_pkg::ADDR_CORRECTION, rd);
        check_word("correction after reset", rd, 32'h0);
        wb_read(host_bus_pkg::ADDR_CONFIG, rd);
        check_word("config after reset", rd, 32'h0);

        // nodes 0,1,2 pair on NS edge 0 and EW edge 0 only
        push_round(8'b0000_0111, 1'b1);
        read_correction(corr);
        check_corr("ns/ew pair", corr, (decoder_geometry_pkg::corr_vec_t'(1) <<
                   decoder_geometry_pkg::NS_BASE) | (decoder_geometry_pkg::corr_vec_t'(1) <<
                   decoder_geometry_pkg::EW_BASE));
        set_fusion(1'b1);
        wb_read(host_bus_pkg::ADDR_CONFIG, rd);
        check_word("config", rd, 32'h1);

        // nodes (1,0) and (2,1) straddle the fusion row
        set_fusion(1'b0);
        push_round(8'b0010_0100, 1'b1);
        read_correction(corr);
        check_corr("cut fusion edge", corr, '0);
        set_fusion(1'b1);
        push_round(8'b0010_0100, 1'b1);
        read_correction(corr);
        check_corr("fused edge", corr, decoder_geometry_pkg::corr_vec_t'(1) <<
                   (decoder_geometry_pkg::NS_BASE + (decoder_geometry_pkg::FUSION_ROW - 1) *
                    decoder_geometry_pkg::GRID_WIDTH_Z));

        for (int r = 0; r < RANDOM_ROUNDS; r++) begin
            if ($urandom_range(1, 0) == 1) begin
                set_fusion(!fusion);
            end
            if (outstanding == host_bus_pkg::CORR_FIFO_DEPTH) begin
                read_correction(corr);
            end
            push_round(decoder_geometry_pkg::node_vec_t'($urandom), $urandom_range(3, 0) == 0);
        end
        while (outstanding > 0) begin
            read_correction(corr);
        end

        // fill every slot so that a fifth round has to wait for a pop
        for (int r = 0; r < host_bus_pkg::CORR_FIFO_DEPTH; r++) begin
            push_round(decoder_geometry_pkg::node_vec_t'($urandom), r == 0);
        end
        meas = decoder_geometry_pkg::node_vec_t'($urandom);
        bus_cycle(1'b1, host_bus_pkg::ADDR_ROUND, round_word(meas, 1'b0), STALL_CYCLES,
                  acked, rd);
        if (acked) begin
            report_failure("a round write was acked while the correction buffer was full");
        end
        read_correction(corr);
        push_round(meas, 1'b0);
        while (outstanding > 0) begin
            read_correction(corr);
        end

        // nothing is left behind once every correction has been popped
        wb_read(host_bus_pkg::ADDR_CORRECTION, rd);
        check_word("correction after drain", rd, 32'h0);

        $display("TB PASSED");
        $finish;
    end

endmodule

// File: flist.f
design/decoder_geometry_pkg.sv
design/host_bus_pkg.sv
design/wb_host_port.sv
design/syndrome_diff.sv
design/pair_matcher.sv
design/correction_buffer.sv
design/surface_decoder_top.sv
test/surface_decoder_assert.sv
test/surface_decoder_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= surface_decoder_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB PASSED" $(LOG); then echo "simulation passed"; \
	else echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
